// File: source/mips_pkg.sv
package mips_pkg;

  // widths that carry a meaning
  typedef logic [31:0] word_t;      // data, address or instruction
  typedef logic [4:0]  reg_addr_t;  // register number
  typedef logic [4:0]  shamt_t;     // shift amount field
  typedef logic [5:0]  opcode_t;    // primary opcode
  typedef logic [5:0]  funct_t;     // r-type function code
  typedef logic [15:0] imm_t;       // i-type immediate

  // bus sequencing, one instruction walks FETCH -> MEM -> EXEC
  typedef enum logic [1:0] {
    FETCH,
    MEM,
    EXEC,
    HALTED
  } cpu_state_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,   // signed compare
    ALU_SLTU,  // unsigned compare
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_LUI    // immediate into upper half
  } alu_op_t;

  // primary opcodes
  localparam opcode_t OP_RTYPE = 6'h00;
  localparam opcode_t OP_J     = 6'h02;
  localparam opcode_t OP_BEQ   = 6'h04;
  localparam opcode_t OP_BNE   = 6'h05;
  localparam opcode_t OP_ADDIU = 6'h09;
  localparam opcode_t OP_SLTI  = 6'h0a;
  localparam opcode_t OP_SLTIU = 6'h0b;
  localparam opcode_t OP_ANDI  = 6'h0c;
  localparam opcode_t OP_ORI   = 6'h0d;
  localparam opcode_t OP_XORI  = 6'h0e;
  localparam opcode_t OP_LUI   = 6'h0f;
  localparam opcode_t OP_LW    = 6'h23;
  localparam opcode_t OP_SW    = 6'h2b;

  // function codes under OP_RTYPE
  localparam funct_t FN_SLL  = 6'h00;
  localparam funct_t FN_SRL  = 6'h02;
  localparam funct_t FN_SRA  = 6'h03;
  localparam funct_t FN_JR   = 6'h08;
  localparam funct_t FN_ADDU = 6'h21;
  localparam funct_t FN_SUBU = 6'h23;
  localparam funct_t FN_AND  = 6'h24;
  localparam funct_t FN_OR   = 6'h25;
  localparam funct_t FN_XOR  = 6'h26;
  localparam funct_t FN_SLT  = 6'h2a;
  localparam funct_t FN_SLTU = 6'h2b;

  localparam word_t      RESET_VECTOR     = 32'hbfc00000;  // boot rom entry
  localparam word_t      HALT_ADDRESS     = 32'h00000000;  // pc landing here stops the core
  localparam reg_addr_t  REG_V0           = 5'd2;
  localparam logic [3:0] FULL_WORD_ENABLE = 4'b1111;       // only word accesses remain

endpackage

// File: source/mips_sequencer.sv
`timescale 1ns/10ps

module mips_sequencer (
  input  logic            clk,
  input  logic            reset,
  input  logic            waitrequest,
  input  mips_pkg::word_t readdata,
  input  logic            mem_read,
  input  logic            mem_write,
  input  mips_pkg::word_t alu_out,
  input  mips_pkg::word_t read_data_b,
  input  logic            redirect,
  input  mips_pkg::word_t branch_target,
  output logic            active,
  output mips_pkg::word_t address,
  output logic            read,
  output logic            write,
  output mips_pkg::word_t writedata,
  output logic [3:0]      byteenable,
  output mips_pkg::word_t instruction,
  output mips_pkg::word_t load_data,
  output mips_pkg::word_t pc,
  output logic            exec_strobe
);
  import mips_pkg::*;

  cpu_state_t state, state_next;
  word_t      target;    // redirect target, waits out the delay slot
  logic       delay;     // high while the delay slot instruction runs
  word_t      pc_next;
  logic       bus_done;  // strobe accepted on this edge
  logic       mem_access;

  assign mem_access = mem_read || mem_write;

  // strobes only once active, so nothing moves during or right after reset
  assign read  = active && (state == FETCH || (state == MEM && mem_read));
  assign write = active && state == MEM && mem_write;
  assign address = (state == MEM) ? {alu_out[31:2], 2'b00} : pc;  // word aligned data
  assign writedata  = read_data_b;
  assign byteenable = FULL_WORD_ENABLE;
  assign bus_done   = (read || write) && !waitrequest;

  assign exec_strobe = (state == EXEC);             // register write and pc step
  assign pc_next     = delay ? target : pc + 32'd4;  // delay slot done, take the target

  always_comb begin
    state_next = state;
    case (state)
      FETCH: begin
        if (bus_done) state_next = MEM;
      end
      MEM: begin
        if (bus_done || !mem_access) state_next = EXEC;  // non-memory ops pass in one cycle
      end
      EXEC: begin
        state_next = (pc_next == HALT_ADDRESS) ? HALTED : FETCH;
      end
      default: state_next = HALTED;  // only reset leaves here
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= FETCH;
      pc     <= RESET_VECTOR;
      delay  <= 1'b0;
      active <= 1'b0;
    end else begin
      state  <= state_next;
      active <= (state_next != HALTED);
      if (state == EXEC) begin
        pc    <= pc_next;
        delay <= redirect;  // next instruction is the delay slot
      end
    end
  end

  // instruction, load word and target registers
  always_ff @(posedge clk) begin
    if (state == FETCH && bus_done) begin
      instruction <= readdata;
    end
    if (state == MEM && read && !waitrequest) begin
      load_data <= readdata;
    end
    if (state == EXEC && redirect) begin
      target <= branch_target;
    end
  end

  strobe_exclusive_a: assert property (@(posedge clk) disable iff (reset)
    !(read && write));

  strobe_aligned_a: assert property (@(posedge clk) disable iff (reset)
    (read || write) |-> address[1:0] == 2'b00);

  // a stalled request keeps its address and its strobe into the next cycle
  strobe_held_a: assert property (@(posedge clk) disable iff (reset)
    (read || write) && waitrequest |=> $stable(address) && (read || write));

endmodule

// File: source/mips_decode.sv
`timescale 1ns/10ps

module mips_decode (
  input  mips_pkg::word_t   instruction,
  output mips_pkg::alu_op_t alu_op,
  output logic              alu_src_imm,   // second operand from the immediate
  output logic              imm_zero_ext,  // logical immediates
  output logic              reg_write,
  output logic              dest_is_rt,    // i-type destination
  output logic              mem_read,
  output logic              mem_write,
  output logic              is_branch,
  output logic              branch_ne,
  output logic              jump,
  output logic              jump_reg
);
  import mips_pkg::*;

  opcode_t opcode;
  funct_t  funct;

  assign opcode = instruction[31:26];
  assign funct  = instruction[5:0];

  always_comb begin
    // anything not listed falls through as a nop
    alu_op       = ALU_ADD;
    alu_src_imm  = 1'b0;
    imm_zero_ext = 1'b0;
    reg_write    = 1'b0;
    dest_is_rt   = 1'b0;
    mem_read     = 1'b0;
    mem_write    = 1'b0;
    is_branch    = 1'b0;
    branch_ne    = 1'b0;
    jump         = 1'b0;
    jump_reg     = 1'b0;
    case (opcode)
      OP_RTYPE: begin
        reg_write = 1'b1;  // cleared again for jr and unknown codes
        case (funct)
          FN_SLL:  alu_op = ALU_SLL;
          FN_SRL:  alu_op = ALU_SRL;
          FN_SRA:  alu_op = ALU_SRA;
          FN_ADDU: alu_op = ALU_ADD;
          FN_SUBU: alu_op = ALU_SUB;
          FN_AND:  alu_op = ALU_AND;
          FN_OR:   alu_op = ALU_OR;
          FN_XOR:  alu_op = ALU_XOR;
          FN_SLT:  alu_op = ALU_SLT;
          FN_SLTU: alu_op = ALU_SLTU;
          FN_JR: begin
            reg_write = 1'b0;
            jump_reg  = 1'b1;
          end
          default: reg_write = 1'b0;
        endcase
      end
      OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW: begin
        alu_src_imm = 1'b1;
        reg_write   = 1'b1;
        dest_is_rt  = 1'b1;
        case (opcode)
          OP_SLTI:  alu_op = ALU_SLT;
          OP_SLTIU: alu_op = ALU_SLTU;  // sign extended, compared unsigned
          OP_ANDI:  alu_op = ALU_AND;
          OP_ORI:   alu_op = ALU_OR;
          OP_XORI:  alu_op = ALU_XOR;
          OP_LUI:   alu_op = ALU_LUI;
          default:  alu_op = ALU_ADD;   // addiu and lw address
        endcase
        imm_zero_ext = (opcode == OP_ANDI || opcode == OP_ORI || opcode == OP_XORI);
        mem_read     = (opcode == OP_LW);
      end
      OP_SW: begin
        alu_src_imm = 1'b1;  // base plus offset
        mem_write   = 1'b1;
      end
      OP_BEQ: is_branch = 1'b1;
      OP_BNE: begin
        is_branch = 1'b1;
        branch_ne = 1'b1;
      end
      OP_J: jump = 1'b1;
      default: ;
    endcase
  end

  always_comb begin
    mem_exclusive_a: assert #0 (!(mem_read && mem_write));
  end

endmodule

// File: source/mips_execute.sv
`timescale 1ns/10ps

module mips_execute (
  input  mips_pkg::word_t   instruction,
  input  mips_pkg::word_t   read_data_a,  // rs
  input  mips_pkg::word_t   read_data_b,  // rt
  input  mips_pkg::alu_op_t alu_op,
  input  logic              alu_src_imm,
  input  logic              imm_zero_ext,
  input  logic              is_branch,
  input  logic              branch_ne,
  input  logic              jump,
  input  logic              jump_reg,
  input  mips_pkg::word_t   pc,
  output mips_pkg::word_t   alu_out,
  output logic              redirect,
  output mips_pkg::word_t   branch_target
);
  import mips_pkg::*;

  imm_t   imm;
  shamt_t shamt;
  word_t  imm_ext;
  word_t  operand_b;
  word_t  pc_plus4;
  word_t  branch_addr;
  word_t  jump_addr;
  logic   operands_equal;
  logic   branch_taken;

  assign imm   = instruction[15:0];
  assign shamt = instruction[10:6];

  // andi, ori, xori take the zero extended form
  assign imm_ext   = imm_zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};
  assign operand_b = alu_src_imm ? imm_ext : read_data_b;

  always_comb begin
    case (alu_op)
      ALU_ADD:  alu_out = read_data_a + operand_b;
      ALU_SUB:  alu_out = read_data_a - operand_b;
      ALU_AND:  alu_out = read_data_a & operand_b;
      ALU_OR:   alu_out = read_data_a | operand_b;
      ALU_XOR:  alu_out = read_data_a ^ operand_b;
      ALU_SLT:  alu_out = {31'd0, $signed(read_data_a) < $signed(operand_b)};
      ALU_SLTU: alu_out = {31'd0, read_data_a < operand_b};
      ALU_SLL:  alu_out = operand_b << shamt;  // shifts act on rt
      ALU_SRL:  alu_out = operand_b >> shamt;
      ALU_SRA:  alu_out = word_t'($signed(operand_b) >>> shamt);
      ALU_LUI:  alu_out = {imm, 16'h0000};
      default:  alu_out = '0;
    endcase
  end

  assign pc_plus4 = pc + 32'd4;

  // branch offset counts words from the delay slot
  assign branch_addr = pc_plus4 + {imm_ext[29:0], 2'b00};
  assign jump_addr   = {pc_plus4[31:28], instruction[25:0], 2'b00};  // stays in the 256 MB region

  always_comb begin
    if (jump_reg) begin
      branch_target = read_data_a;
    end else if (jump) begin
      branch_target = jump_addr;
    end else begin
      branch_target = branch_addr;
    end
  end

  assign operands_equal = (read_data_a == read_data_b);
  assign branch_taken   = is_branch && (operands_equal != branch_ne);  // bne inverts
  assign redirect       = branch_taken || jump || jump_reg;

endmodule

// File: source/mips_writeback.sv
`timescale 1ns/10ps

module mips_writeback (
  input  logic            clk,
  input  logic            reset,
  input  mips_pkg::word_t instruction,
  input  logic            reg_write,
  input  logic            dest_is_rt,
  input  logic            mem_read,     // load word goes to the register
  input  logic            exec_strobe,
  input  mips_pkg::word_t alu_out,
  input  mips_pkg::word_t load_data,
  output mips_pkg::word_t read_data_a,
  output mips_pkg::word_t read_data_b,
  output mips_pkg::word_t register_v0
);
  import mips_pkg::*;

  word_t     regs [32];
  reg_addr_t rs, rt, rd;
  reg_addr_t dest;
  word_t     write_data;
  logic      write_en;

  assign rs = instruction[25:21];
  assign rt = instruction[20:16];
  assign rd = instruction[15:11];

  assign dest       = dest_is_rt ? rt : rd;
  assign write_data = mem_read ? load_data : alu_out;
  assign write_en   = exec_strobe && reg_write && (dest != '0);  // $zero is never written

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en) begin
      regs[dest] <= write_data;
    end
  end

  // combinational reads, operands settle during MEM
  assign read_data_a = regs[rs];
  assign read_data_b = regs[rt];
  assign register_v0 = regs[REG_V0];

  zero_reg_a: assert property (@(posedge clk) disable iff (reset)
    (rs == '0) |-> read_data_a == '0);

endmodule

// File: source/mips_cpu_bus.sv
`timescale 1ns/10ps

module mips_cpu_bus (
  input  logic            clk,
  input  logic            reset,
  output logic            active,
  output mips_pkg::word_t register_v0,
  // avalon master
  output mips_pkg::word_t address,
  output logic            write,
  output logic            read,
  input  logic            waitrequest,
  output mips_pkg::word_t writedata,
  output logic [3:0]      byteenable,
  input  mips_pkg::word_t readdata
);
  import mips_pkg::*;

  word_t   instruction;
  word_t   load_data;
  word_t   pc;
  logic    exec_strobe;
  // decoder levels
  alu_op_t alu_op;
  logic    alu_src_imm, imm_zero_ext, reg_write, dest_is_rt;
  logic    mem_read, mem_write;
  logic    is_branch, branch_ne, jump, jump_reg;
  // datapath
  word_t   read_data_a, read_data_b;
  word_t   alu_out, branch_target;
  logic    redirect;

  mips_sequencer seq_inst (
    .clk(clk), .reset(reset),
    .waitrequest(waitrequest), .readdata(readdata),
    .mem_read(mem_read), .mem_write(mem_write),
    .alu_out(alu_out),               // data address in MEM
    .read_data_b(read_data_b),       // store data
    .redirect(redirect), .branch_target(branch_target),
    .active(active),
    .address(address), .read(read), .write(write),
    .writedata(writedata), .byteenable(byteenable),
    .instruction(instruction), .load_data(load_data),
    .pc(pc), .exec_strobe(exec_strobe)
  );

  mips_decode dec_inst (
    .instruction(instruction),
    .alu_op(alu_op), .alu_src_imm(alu_src_imm), .imm_zero_ext(imm_zero_ext),
    .reg_write(reg_write), .dest_is_rt(dest_is_rt),
    .mem_read(mem_read), .mem_write(mem_write),
    .is_branch(is_branch), .branch_ne(branch_ne),
    .jump(jump), .jump_reg(jump_reg)
  );

  mips_execute exe_inst (
    .instruction(instruction),
    .read_data_a(read_data_a), .read_data_b(read_data_b),
    .alu_op(alu_op), .alu_src_imm(alu_src_imm), .imm_zero_ext(imm_zero_ext),
    .is_branch(is_branch), .branch_ne(branch_ne),
    .jump(jump), .jump_reg(jump_reg),
    .pc(pc),                         // pc of the instruction in flight
    .alu_out(alu_out), .redirect(redirect), .branch_target(branch_target)
  );

  mips_writeback wb_inst (
    .clk(clk), .reset(reset),
    .instruction(instruction),
    .reg_write(reg_write), .dest_is_rt(dest_is_rt), .mem_read(mem_read),
    .exec_strobe(exec_strobe),
    .alu_out(alu_out), .load_data(load_data),
    .read_data_a(read_data_a), .read_data_b(read_data_b),
    .register_v0(register_v0)
  );

endmodule

// File: verification/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
  output logic clk
);

  localparam real HALF_PERIOD = 4.0;  // ns, full period 8 ns

  initial begin
    clk = 1'b0;
  end

  always #(HALF_PERIOD) clk = ~clk;

endmodule

// File: verification/mips_checker.sv
`timescale 1ns/10ps

module mips_checker (
  input  logic            clk,
  input  logic            reset,
  input  logic            active,
  input  mips_pkg::word_t register_v0,
  input  mips_pkg::word_t address,
  input  logic            read,
  input  logic            write,
  input  logic            waitrequest,
  input  logic [3:0]      byteenable,
  input  mips_pkg::word_t stored_word,    // memory model's data word
  input  mips_pkg::word_t data_address,
  input  int              test_id,
  input  mips_pkg::word_t expected_v0,
  input  mips_pkg::word_t expected_word,
  output logic            test_done,
  output int              passed_count,
  output int              failed_count
);
  import mips_pkg::*;

  localparam int HALT_WATCH_CYCLES = 8;  // quiet bus expected after the halt

  logic reset_prev;
  logic active_seen;
  logic first_read_checked;
  logic data_since_fetch;   // last accepted access went to the data word
  logic accepted;
  int   halt_cycles;
  int   test_errors;

  assign accepted = (read || write) && !waitrequest;

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("failure at %0t: %s", $time, what);
    test_errors++;
  endtask

  task automatic finish_test();
    if (test_errors == 0) begin
      $display("test %0d passed", test_id);
      passed_count++;
    end else begin
      $display("test %0d failed with %0d errors", test_id, test_errors);
      failed_count++;
    end
    test_done <= 1'b1;
  endtask

  initial begin
    reset_prev         = 1'b0;
    active_seen        = 1'b0;
    first_read_checked = 1'b0;
    data_since_fetch   = 1'b0;
    halt_cycles        = 0;
    test_errors        = 0;
    test_done          = 1'b0;
    passed_count       = 0;
    failed_count       = 0;
  end

  always @(posedge clk) begin
    reset_prev <= reset;
    if (reset) begin
      if (!reset_prev) test_errors = 0;  // new test begins
      if (reset_prev) begin              // outputs settled after the first reset edge
        check_value("read during reset", 32'd0, read);
        check_value("write during reset", 32'd0, write);
        check_value("active during reset", 32'd0, active);
      end
      active_seen        <= 1'b0;
      first_read_checked <= 1'b0;
      data_since_fetch   <= 1'b0;
      halt_cycles        <= 0;
      test_done          <= 1'b0;
    end else begin
      if (active) active_seen <= 1'b1;
      if (read && !first_read_checked) begin
        check_value("first fetch address", 32'hbfc00000, address);  // boot rom entry
        first_read_checked <= 1'b1;
      end
      if (accepted && write) begin
        check_value("byteenable", 4'b1111, byteenable);  // word stores only
        if (address !== data_address) begin
          report_failure($sformatf("store to unexpected address %h", address));
        end
      end
      // each data access needs its own fetch, so a repeat shows up here
      if (accepted) begin
        if (address === data_address) begin
          if (data_since_fetch) begin
            report_failure("two data accesses without an instruction fetch between them");
          end
          data_since_fetch <= 1'b1;
        end else begin
          data_since_fetch <= 1'b0;
        end
      end
      if (active_seen && !active) begin
        if (read || write) report_failure("bus strobe after the cpu halted");
        if (!test_done && halt_cycles == HALT_WATCH_CYCLES) begin
          check_value("register_v0", expected_v0, register_v0);
          check_value("data word", expected_word, stored_word);
          finish_test();
        end
        halt_cycles <= halt_cycles + 1;
      end
    end
  end

endmodule

// File: verification/mips_tb.sv
`timescale 1ns/10ps

module mips_tb;
  import mips_pkg::*;

  localparam int          CLK_PERIOD      = 8;    // ns, same as tb_clock
  localparam int          RESET_CYCLES    = 16;
  localparam int          CYCLES_PER_TEST = 400;  // watchdog budget
  localparam int          MEM_DEPTH       = 64;   // program words per test
  localparam int          PATTERN_DEPTH   = 256;
  localparam logic [31:0] LFSR_SEED       = 32'haa23;
  localparam logic [31:0] LFSR_TAPS       = 32'h80200003;  // x^32 + x^22 + x^2 + x + 1
  localparam word_t       DATA_ADDRESS    = 32'h00001000;

  logic       clk;
  logic       reset;
  logic       waitrequest;
  logic       active;
  logic       read;
  logic       write;
  word_t      readdata;
  word_t      register_v0;
  word_t      address;
  word_t      writedata;
  logic [3:0] byteenable;

  word_t       patterns [PATTERN_DEPTH];  // raw pattern file words
  word_t       program_mem [MEM_DEPTH];   // mapped at RESET_VECTOR
  word_t       data_word;                 // the single word at DATA_ADDRESS
  int          program_length;
  logic [31:0] lfsr_state;

  int    test_count;
  int    test_id;
  int    load_errors;
  word_t expected_v0;
  word_t expected_word;
  logic  tests_loaded;
  logic  test_done;
  int    passed_count;
  int    failed_count;

  tb_clock clock_gen (.clk(clk));

  mips_cpu_bus uut (
    .clk(clk), .reset(reset),
    .active(active), .register_v0(register_v0),
    .address(address), .write(write), .read(read),
    .waitrequest(waitrequest), .writedata(writedata),
    .byteenable(byteenable), .readdata(readdata)
  );

  mips_checker check_inst (
    .clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
    .address(address), .read(read), .write(write), .waitrequest(waitrequest),
    .byteenable(byteenable),
    .stored_word(data_word), .data_address(DATA_ADDRESS),
    .test_id(test_id), .expected_v0(expected_v0), .expected_word(expected_word),
    .test_done(test_done), .passed_count(passed_count), .failed_count(failed_count)
  );

  // galois form, shifts right and folds the taps in when a one drops out
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) next = next ^ LFSR_TAPS;
    return next;
  endfunction

  function automatic word_t fill_word(input word_t addr);
    return ~addr;  // unused locations differ by address
  endfunction

  function automatic word_t memory_word(input word_t addr);
    word_t offset;
    offset = addr - RESET_VECTOR;
    if (addr == DATA_ADDRESS) return data_word;
    if ((offset >> 2) < MEM_DEPTH) return program_mem[offset >> 2];
    return fill_word(addr);
  endfunction

  // record layout: id, length, program words, data word, expected v0, expected word
  task automatic load_test(input int ptr);
    test_id        = patterns[ptr];
    program_length = patterns[ptr + 1];
    if (program_length > MEM_DEPTH) begin
      $display("test %0d program does not fit the memory model", test_id);
      load_errors++;
    end
    for (int i = 0; i < MEM_DEPTH; i++) begin
      program_mem[i] = (i < program_length) ? patterns[ptr + 2 + i]
                                            : fill_word(RESET_VECTOR + 4 * i);
    end
    data_word     = patterns[ptr + 2 + program_length];
    expected_v0   = patterns[ptr + 3 + program_length];
    expected_word = patterns[ptr + 4 + program_length];
  endtask

  // random back-pressure, one lfsr bit per cycle
  always @(negedge clk) begin
    waitrequest <= lfsr_state[0];
    lfsr_state  <= lfsr_next(lfsr_state);
    readdata    <= memory_word(address);  // settled long before the next rising edge
  end

  always @(posedge clk) begin
    if (write && !waitrequest && address == DATA_ADDRESS) begin
      data_word <= writedata;
    end
  end

  initial begin : main
    int ptr;
    reset        = 1'b1;
    waitrequest  = 1'b1;
    readdata     = '0;
    lfsr_state   = LFSR_SEED;
    load_errors  = 0;
    tests_loaded = 1'b0;
    $readmemh("verification/mips_patterns.mem", patterns);
    test_count   = patterns[0];
    tests_loaded = 1'b1;
    ptr = 1;
    for (int t = 0; t < test_count; t++) begin
      @(negedge clk);
      reset = 1'b1;
      load_test(ptr);
      ptr += 5 + program_length;
      repeat (RESET_CYCLES) @(negedge clk);
      reset = 1'b0;  // released on a falling edge
      wait (test_done === 1'b1);
    end
    $display("%0d tests run, %0d passed, %0d failed", test_count, passed_count, failed_count);
    if (test_count > 0 && failed_count == 0 && load_errors == 0 &&
        passed_count == test_count) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin : watchdog
    wait (tests_loaded === 1'b1);
    #(test_count * CYCLES_PER_TEST * CLK_PERIOD);
    $display("timeout: test %0d never halted", test_id);
    $display("Test failures found");
    $finish;
  end

endmodule

// File: sources.f
source/mips_pkg.sv
source/mips_sequencer.sv
source/mips_decode.sv
source/mips_execute.sv
source/mips_writeback.sv
source/mips_cpu_bus.sv
verification/tb_clock.sv
verification/mips_checker.sv
verification/mips_tb.sv

// File: Bender.yml
package:
  name: mips_cpu_bus

sources:
  - files:
      - source/mips_pkg.sv
      - source/mips_sequencer.sv
      - source/mips_decode.sv
      - source/mips_execute.sv
      - source/mips_writeback.sv
      - source/mips_cpu_bus.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/mips_checker.sv
      - verification/mips_tb.sv

// File: verification/mips_patterns.mem
// records: test id, program length, program words from 0xbfc00000,
// data word at 0x1000, expected register_v0, expected word at 0x1000
00000003
// 1: immediates, register ops, shifts, compares, lui
00000001 00000014
24081234 3c098000 00095103 00095902 0148602a 0148682b
00087200 01cb1026 004c1025 00481023 314fffff 35ef00f0
2958ffff 004f1021 00581021 3842ff00 010ec824 00591021
00000008 24420001
deadbeef 0812edbf deadbeef
// 2: lw, modify, sw, lw back
00000002 00000009
24081000 8d090000 25290101 3c0a1100 012a4821 ad090000
8d020000 00000008 24420002
12345678 2334577b 23345779
// 3: beq and bne taken and not taken, j, delay slots
00000003 00000012
24080005 24090005 11090002 24420001 24420100 15090003
24420010 24420020 15000002 24420002 24420200 11000002
24420040 0bf00010 24420004 24420400 00000008 24420008
cafef00d 0000007f cafef00d
